/* all.f */
+incdir+rtl
rtl/spi_pkg.sv
rtl/spi_fifo.sv
rtl/spi_regs.sv
rtl/spi_master.sv
rtl/spi_slave.sv
rtl/spi_loopback.sv
tests/spi_loopback_tb.sv

/* rtl/spi_config.svh */
`ifndef SPI_CONFIG_SVH
`define SPI_CONFIG_SVH

// ######################################################################
// Bus widths
`define SPI_AW 32                      // Emesh address width
`define SPI_DW 32                      // Emesh data width
`define SPI_PW 104                     // Full emesh packet

// Queue depths
`define SPI_TX_DEPTH  4
`define SPI_RX_DEPTH  4
`define SPI_RSP_DEPTH 4                // Pending read responses

// ######################################################################
// Register byte offsets, decoded on dstaddr[4:2]
`define SPI_REG_CONFIG      5'h00
`define SPI_REG_STATUS      5'h04
`define SPI_REG_TX          5'h08
`define SPI_REG_RX          5'h0C
`define SPI_REG_SLAVE_COUNT 5'h10

`endif

/* rtl/spi_fifo.sv */
`default_nettype none

module spi_fifo #(
   parameter type item_t = logic [7:0],
   parameter int  DEPTH  = 4
) (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       push,
   input  item_t                      push_data,
   input  logic                       pop,
   output item_t                      pop_data,
   output logic                       full,
   output logic                       empty,
   output logic [$clog2(DEPTH+1)-1:0] count
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH+1);

   item_t            mem [DEPTH];      // Storage, no reset
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic             do_push;
   logic             do_pop;

   assign full     = (count == CNT_W'(DEPTH));
   assign empty    = (count == '0);
   assign do_push  = push & ~full;     // Drop when full
   assign do_pop   = pop & ~empty;
   assign pop_data = mem[rd_ptr];      // Head always visible

   // Pointers and fill level
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;                 // Both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (do_push)
         mem[wr_ptr] <= push_data;
   end

endmodule

`default_nettype wire

/* rtl/spi_loopback.sv */
`default_nettype none

module spi_loopback
   import spi_pkg::*;
(
   input  logic          clk,
   input  logic          arst_n,
   input  logic          access_in,
   input  emesh_packet_t packet_in,
   output logic          wait_out,
   output logic          access_out,
   output emesh_packet_t packet_out,
   input  logic          wait_in,
   output logic          spi_irq
);

   // Byte streams between registers and master
   spi_byte_t  tx_byte;
   logic       tx_valid;
   logic       tx_ready;
   spi_byte_t  rx_byte;
   logic       rx_valid;
   logic       busy;
   spi_cfg_t   cfg;
   logic [7:0] slave_count;

   // Serial lines, internal only
   logic       sclk;
   logic       mosi;
   logic       ss_n;
   logic       miso;

   // ######################################################################
   // Emesh register block

   spi_regs spi_regs_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in),
      .tx_byte    (tx_byte),
      .tx_valid   (tx_valid),
      .tx_ready   (tx_ready),
      .rx_byte    (rx_byte),
      .rx_valid   (rx_valid),
      .busy       (busy),
      .slave_count(slave_count),
      .cfg        (cfg),
      .spi_irq    (spi_irq)
   );

   // ######################################################################
   // Master and looped back slave

   spi_master spi_master_i (
      .clk(clk), .arst_n(arst_n), .cfg(cfg),
      .tx_byte(tx_byte), .tx_valid(tx_valid), .tx_ready(tx_ready),
      .rx_byte(rx_byte), .rx_valid(rx_valid), .busy(busy),
      .sclk(sclk), .mosi(mosi), .ss_n(ss_n), .miso(miso)
   );

   spi_slave spi_slave_i (
      .clk(clk), .arst_n(arst_n),
      .sclk(sclk), .mosi(mosi), .ss_n(ss_n),
      .miso(miso),                     // Back to master
      .slave_count(slave_count)
   );

endmodule

`default_nettype wire

/* rtl/spi_master.sv */
`default_nettype none

module spi_master
   import spi_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  spi_cfg_t  cfg,
   input  spi_byte_t tx_byte,
   input  logic      tx_valid,
   output logic      tx_ready,
   output spi_byte_t rx_byte,
   output logic      rx_valid,
   output logic      busy,
   output logic      sclk,
   output logic      mosi,
   output logic      ss_n,
   input  logic      miso
);

   logic       active;                 // Byte in flight
   logic [7:0] div_cnt;                // Cycles within half period
   logic [3:0] half_cnt;               // 16 halves per byte
   logic       half_done;
   logic       sclk_q;
   logic       ss_q;
   logic       rx_pulse;
   spi_byte_t  tx_sh;
   spi_byte_t  rx_sh;

   // ######################################################################
   // Start and divider

   // Take a byte only from idle
   assign tx_ready  = ~active & cfg.enable & tx_valid;
   assign half_done = active & (div_cnt == cfg.clkdiv);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         active   <= 1'b0;
         div_cnt  <= '0;
         half_cnt <= '0;
         sclk_q   <= 1'b0;
         ss_q     <= 1'b1;
         rx_pulse <= 1'b0;
         tx_sh    <= '0;
      end else begin
         rx_pulse <= 1'b0;
         if (tx_ready) begin
            active   <= 1'b1;
            ss_q     <= 1'b0;          // Select for the whole byte
            div_cnt  <= '0;
            half_cnt <= '0;
            sclk_q   <= 1'b0;
            tx_sh    <= tx_byte;       // MSB out first
         end else if (half_done) begin
            div_cnt  <= '0;
            sclk_q   <= ~sclk_q;
            half_cnt <= half_cnt + 1'b1;
            if (sclk_q)
               tx_sh <= {tx_sh[6:0], 1'b0};   // Next bit on falling edge
            if (half_cnt == 4'd15) begin
               // Last falling edge ends the byte
               active   <= 1'b0;
               ss_q     <= 1'b1;
               rx_pulse <= 1'b1;
            end
         end else if (active) begin
            div_cnt <= div_cnt + 1'b1;
         end
      end
   end

   // ######################################################################
   // Receive shift

   // Sample miso as sclk goes high
   always_ff @(posedge clk) begin
      if (half_done && !sclk_q)
         rx_sh <= {rx_sh[6:0], miso};
   end

   assign sclk     = sclk_q;
   assign ss_n     = ss_q;
   assign mosi     = tx_sh[7];
   assign busy     = active;
   assign rx_byte  = rx_sh;            // Complete when rx_valid pulses
   assign rx_valid = rx_pulse;

endmodule

`default_nettype wire

/* rtl/spi_pkg.sv */
`default_nettype none

`include "spi_config.svh"

package spi_pkg;

   // ######################################################################
   // Serial data

   // One byte on the wire
   typedef logic [7:0] spi_byte_t;

   // ######################################################################
   // Emesh packet, MSB first

   typedef struct packed {
      logic               write;       // 1 for write, 0 for read
      logic [1:0]         datamode;    // 2'b10 is a 32 bit word
      logic [4:0]         ctrlmode;
      logic [`SPI_AW-1:0] dstaddr;     // Register address on requests
      logic [`SPI_DW-1:0] data;        // Write data or read data
      logic [`SPI_AW-1:0] srcaddr;     // Return address for reads
   } emesh_packet_t;

   // ######################################################################
   // Register layouts

   // CONFIG, packed into data[9:0]
   typedef struct packed {
      logic       enable;              // Allows transfers to start
      logic       irq_en;              // Interrupt on RX data
      logic [7:0] clkdiv;              // Half period is clkdiv+1 cycles
   } spi_cfg_t;

   // STATUS, packed into data[5:0]
   typedef struct packed {
      logic       busy;                // Master shifting
      logic       tx_full;
      logic       tx_overflow;         // Sticky until STATUS write
      logic [2:0] rx_count;            // Bytes waiting in RX
   } spi_status_t;

   // Response packets always carry a full word
   localparam logic [1:0] DATAMODE_WORD = 2'b10;

endpackage

`default_nettype wire

/* rtl/spi_regs.sv */
`default_nettype none

`include "spi_config.svh"

module spi_regs
   import spi_pkg::*;
(
   input  logic          clk,
   input  logic          arst_n,
   input  logic          access_in,
   input  emesh_packet_t packet_in,
   output logic          wait_out,
   output logic          access_out,
   output emesh_packet_t packet_out,
   input  logic          wait_in,
   output spi_byte_t     tx_byte,
   output logic          tx_valid,
   input  logic          tx_ready,
   input  spi_byte_t     rx_byte,
   input  logic          rx_valid,
   input  logic          busy,
   input  logic [7:0]    slave_count,
   output spi_cfg_t      cfg,
   output logic          spi_irq
);

   spi_status_t        status;
   logic               tx_overflow;
   logic               req_acc, req_wr, req_rd;
   logic [4:0]         reg_off;        // Byte offset from dstaddr[4:2]
   logic [`SPI_DW-1:0] rd_data;
   emesh_packet_t      rsp_pkt;
   logic               tx_push, tx_full, tx_empty;
   logic               rx_pop, rx_empty;
   logic [2:0]         rx_count;
   spi_byte_t          rx_head;
   logic               rsp_push, rsp_pop, rsp_full, rsp_empty;

   // ######################################################################
   // Request decode

   assign wait_out = rsp_full;         // Stall everything on full response queue
   assign req_acc  = access_in & ~wait_out;
   assign req_wr   = req_acc & packet_in.write;
   assign req_rd   = req_acc & ~packet_in.write;
   assign reg_off  = {packet_in.dstaddr[4:2], 2'b00};
   assign tx_push  = req_wr & (reg_off == `SPI_REG_TX);

   assign status.busy        = busy;
   assign status.tx_full     = tx_full;
   assign status.tx_overflow = tx_overflow;
   assign status.rx_count    = rx_count;

   // CONFIG and sticky overflow
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cfg         <= '0;
         tx_overflow <= 1'b0;
      end else if (req_wr) begin
         if (reg_off == `SPI_REG_CONFIG)
            cfg <= spi_cfg_t'(packet_in.data[$bits(spi_cfg_t)-1:0]);
         if (reg_off == `SPI_REG_STATUS)
            tx_overflow <= 1'b0;       // Any STATUS write clears
         if (tx_push && tx_full)
            tx_overflow <= 1'b1;       // Byte lost
      end
   end

   // Read mux, RX pops on read
   always_comb begin
      rd_data = '0;
      rx_pop  = 1'b0;
      case (reg_off)
         `SPI_REG_CONFIG: rd_data[$bits(spi_cfg_t)-1:0] = cfg;
         `SPI_REG_STATUS: rd_data[$bits(spi_status_t)-1:0] = status;
         `SPI_REG_RX: begin
            rx_pop = req_rd & ~rx_empty;
            if (!rx_empty)
               rd_data[7:0] = rx_head;  // Empty queue reads 0
         end
         `SPI_REG_SLAVE_COUNT: rd_data[7:0] = slave_count;
         default: ;                     // TX and unmapped read 0
      endcase
   end

   // ######################################################################
   // Response build, addresses swapped

   always_comb begin
      rsp_pkt.write    = 1'b0;
      rsp_pkt.datamode = DATAMODE_WORD;
      rsp_pkt.ctrlmode = '0;
      rsp_pkt.dstaddr  = packet_in.srcaddr;
      rsp_pkt.data     = rd_data;
      rsp_pkt.srcaddr  = packet_in.dstaddr;
   end

   assign rsp_push   = req_rd;          // Never full here
   assign access_out = ~rsp_empty;
   assign rsp_pop    = access_out & ~wait_in;
   assign tx_valid   = ~tx_empty;
   assign spi_irq    = cfg.irq_en & (rx_count != '0);

   // ######################################################################
   // Queues

   spi_fifo #(.item_t(spi_byte_t), .DEPTH(`SPI_TX_DEPTH)) tx_fifo_i (
      .clk(clk), .arst_n(arst_n),
      .push(tx_push), .push_data(packet_in.data[7:0]),
      .pop(tx_ready), .pop_data(tx_byte),
      .full(tx_full), .empty(tx_empty), .count()
   );

   spi_fifo #(.item_t(spi_byte_t), .DEPTH(`SPI_RX_DEPTH)) rx_fifo_i (
      .clk(clk), .arst_n(arst_n),
      .push(rx_valid), .push_data(rx_byte),
      .pop(rx_pop), .pop_data(rx_head),
      .full(), .empty(rx_empty), .count(rx_count)
   );

   spi_fifo #(.item_t(emesh_packet_t), .DEPTH(`SPI_RSP_DEPTH)) rsp_fifo_i (
      .clk(clk), .arst_n(arst_n),
      .push(rsp_push), .push_data(rsp_pkt),
      .pop(rsp_pop), .pop_data(packet_out),
      .full(rsp_full), .empty(rsp_empty), .count()
   );

endmodule

`default_nettype wire

/* rtl/spi_slave.sv */
`default_nettype none

module spi_slave
   import spi_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       sclk,
   input  logic       mosi,
   input  logic       ss_n,
   output logic       miso,
   output logic [7:0] slave_count
);

   logic      sclk_d;                  // Previous sclk sample
   logic      ss_d;                    // Previous select sample
   logic      sclk_rise;
   logic      ss_rise;
   spi_byte_t rx_sh;                   // Incoming byte
   spi_byte_t tx_sh;                   // Reply, previous byte

   // ######################################################################
   // Edge detect

   // Clocks only count while selected
   assign sclk_rise = sclk & ~sclk_d & ~ss_n;
   assign ss_rise   = ss_n & ~ss_d;    // End of byte

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sclk_d <= 1'b0;
         ss_d   <= 1'b1;
      end else begin
         sclk_d <= sclk;
         ss_d   <= ss_n;
      end
   end

   // ######################################################################
   // Shift and reply

   always_ff @(posedge clk) begin
      if (sclk_rise)
         rx_sh <= {rx_sh[6:0], mosi};  // MSB arrives first
   end

   // Reply byte is loaded as select rises
   // and advanced one cycle after each rising sclk
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tx_sh       <= '0;            // First reply is zero
         slave_count <= '0;
      end else if (ss_rise) begin
         tx_sh       <= rx_sh;
         slave_count <= slave_count + 1'b1;
      end else if (sclk_rise) begin
         tx_sh <= {tx_sh[6:0], 1'b0};
      end
   end

   // Bit ready before the master samples it
   assign miso = tx_sh[7];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the loopback regression with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -Wno-fatal -f all.f --top-module spi_loopback_tb -o spi_sim \
   && { ./obj_dir/spi_sim > sim.log 2>&1 || true; } \
   && cat sim.log \
   && grep -q "^Regression passed$" sim.log \
   && echo "Simulation OK" \
   || { echo "Simulation FAILED, see sim.log"; exit 1; }

/* tests/spi_loopback_tb.sv */
`default_nettype none

`include "spi_config.svh"

module spi_loopback_tb
   import spi_pkg::*;
;
   timeunit 1ns;
   timeprecision 100ps;

   // Bytes times 16 half periods times (clkdiv+1), per test, plus margin
   localparam int TIMEOUT = 4*16*(0+1) + 4*16*(3+1) + 1*16*(1+1) + 2000;
   localparam logic [31:0] BASE = 32'h8000_0000;   // Any upper bits, decode is 4:2

   logic          clk;
   logic          arst_n;
   logic          access_in;
   emesh_packet_t packet_in;
   logic          wait_out;
   logic          access_out;
   emesh_packet_t packet_out;
   logic          wait_in;
   logic          spi_irq;

   int            cycles;
   int            sent_total;          // Bytes the slave has seen
   logic [7:0]    prev_rx;             // Next expected slave reply
   logic [31:0]   exp_cfg;             // Last CONFIG written

   spi_loopback spi_loopback_i (
      .clk(clk), .arst_n(arst_n),
      .access_in(access_in), .packet_in(packet_in), .wait_out(wait_out),
      .access_out(access_out), .packet_out(packet_out), .wait_in(wait_in),
      .spi_irq(spi_irq)
   );

   // ######################################################################
   // Clock and watchdog

   initial clk = 1'b0;
   always #10 clk = ~clk;              // 20 ns period

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == TIMEOUT) begin
         $display("Timeout after %0d cycles, DUT stopped responding", cycles);
         $display("Regression failed");
         $fatal(1, "Run aborted");
      end
   end

   // ######################################################################
   // Helpers

   task automatic check(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
      if (actual !== expected) begin
         $display("Mismatch at %0t: %s got 0x%08h expected 0x%08h",
                  $time, name, actual, expected);
         $display("Regression failed");
         $fatal(1, "Stopped at first error");
      end
   endtask

   // CONFIG layout {enable, irq_en, clkdiv} in data[9:0]
   function automatic logic [31:0] cfg_word(input logic en, input logic irq,
                                            input logic [7:0] div);
      cfg_word = {22'd0, en, irq, div};
   endfunction

   task automatic send_req(input emesh_packet_t req);
      @(posedge clk);
      access_in <= 1'b1;
      packet_in <= req;
      do @(negedge clk); while (wait_out);   // Accepted on next rising edge
      @(posedge clk);
      access_in <= 1'b0;
   endtask

   task automatic get_rsp(output emesh_packet_t rsp);
      do @(negedge clk); while (!access_out);
      rsp = packet_out;
      @(posedge clk);                  // Consumed here, wait_in low
   endtask

   // Response fields follow from the request
   task automatic check_rsp(input emesh_packet_t req, input emesh_packet_t rsp);
      check("packet_out.write", rsp.write, 0);
      check("packet_out.datamode", rsp.datamode, 2'b10);
      check("packet_out.ctrlmode", rsp.ctrlmode, 0);
      check("packet_out.dstaddr", rsp.dstaddr, req.srcaddr);   // Swapped
      check("packet_out.srcaddr", rsp.srcaddr, req.dstaddr);
   endtask

   function automatic emesh_packet_t read_pkt(input logic [4:0] off);
      read_pkt          = '0;
      read_pkt.datamode = 2'b10;
      read_pkt.dstaddr  = BASE | 32'(off);
      read_pkt.srcaddr  = $urandom;    // Return address
   endfunction

   task automatic write_reg(input logic [4:0] off, input logic [31:0] data);
      emesh_packet_t req;
      req          = '0;
      req.write    = 1'b1;
      req.datamode = 2'b10;
      req.dstaddr  = BASE | 32'(off);
      req.data     = data;
      send_req(req);
   endtask

   task automatic read_reg(input logic [4:0] off, output logic [31:0] data);
      emesh_packet_t req;
      emesh_packet_t rsp;
      req = read_pkt(off);
      send_req(req);
      get_rsp(rsp);
      check_rsp(req, rsp);
      data = rsp.data;
   endtask

   // Poll STATUS until idle with n bytes in RX
   task automatic wait_idle(input int n);
      logic [31:0] st;
      do begin
         read_reg(`SPI_REG_STATUS, st);
      end while (st[5] || st[2:0] != 3'(n));
   endtask

   // ######################################################################
   // Tests

   task automatic reset_values();
      logic [31:0] d;
      @(negedge clk);
      check("access_out", access_out, 0);
      check("wait_out", wait_out, 0);
      check("spi_irq", spi_irq, 0);
      read_reg(`SPI_REG_CONFIG, d);
      check("CONFIG", d, 0);
      read_reg(`SPI_REG_STATUS, d);
      check("STATUS", d, 0);
   endtask

   task automatic register_access();
      logic [31:0] d;
      exp_cfg = $urandom & 32'h3FF;    // Random enable, irq_en, clkdiv
      write_reg(`SPI_REG_CONFIG, exp_cfg);
      read_reg(`SPI_REG_CONFIG, d);
      check("CONFIG", d, exp_cfg);
      read_reg(5'h14, d);              // Unmapped
      check("unmapped", d, 0);
      read_reg(`SPI_REG_TX, d);
      check("TX read", d, 0);
   endtask

   task automatic loopback_run(input logic [7:0] div, input int n);
      logic [7:0]  sent [4];
      logic [31:0] d;
      exp_cfg = cfg_word(1'b1, 1'b0, div);
      write_reg(`SPI_REG_CONFIG, exp_cfg);
      for (int i = 0; i < n; i++) begin
         sent[i] = 8'($urandom);
         write_reg(`SPI_REG_TX, {24'd0, sent[i]});
      end
      wait_idle(n);
      for (int i = 0; i < n; i++) begin
         read_reg(`SPI_REG_RX, d);
         check("RX data", d, {24'd0, prev_rx});   // Slave echoes the byte before
         prev_rx = sent[i];
      end
      sent_total += n;
      read_reg(`SPI_REG_SLAVE_COUNT, d);
      check("SLAVE_COUNT", d, 32'(sent_total));
   endtask

   task automatic backpressure();
      emesh_packet_t reqs[$];
      emesh_packet_t req;
      emesh_packet_t rsp;
      @(posedge clk);
      wait_in <= 1'b1;
      @(negedge clk);
      while (!wait_out) begin
         if (reqs.size() >= 2*`SPI_RSP_DEPTH) begin
            $display("wait_out never rose while responses were held back");
            $display("Regression failed");
            $fatal(1, "Back-pressure broken");
         end
         // Alternate two registers with known values
         req = read_pkt(reqs.size() % 2 ? `SPI_REG_SLAVE_COUNT : `SPI_REG_CONFIG);
         send_req(req);
         reqs.push_back(req);
         @(negedge clk);
      end
      check("queued reads", reqs.size(), `SPI_RSP_DEPTH);
      repeat (3) begin                 // Head holds steady while stalled
         @(negedge clk);
         check("access_out", access_out, 1);
         check("packet_out.dstaddr", packet_out.dstaddr, reqs[0].srcaddr);
      end
      @(posedge clk);
      wait_in <= 1'b0;
      foreach (reqs[i]) begin
         get_rsp(rsp);
         check_rsp(reqs[i], rsp);
         check("packet_out.data", rsp.data, i % 2 ? 32'(sent_total) : exp_cfg);
      end
   endtask

   task automatic irq_and_overflow();
      logic [31:0] d;
      write_reg(`SPI_REG_CONFIG, cfg_word(1'b1, 1'b0, 8'd1));
      write_reg(`SPI_REG_TX, 32'h0000_005A);
      wait_idle(1);
      @(negedge clk);
      check("spi_irq", spi_irq, 0);    // Data waiting but irq_en off
      write_reg(`SPI_REG_CONFIG, cfg_word(1'b1, 1'b1, 8'd1));
      @(negedge clk);
      check("spi_irq", spi_irq, 1);
      read_reg(`SPI_REG_RX, d);
      check("RX data", d, {24'd0, prev_rx});
      prev_rx = 8'h5A;
      sent_total += 1;
      @(negedge clk);
      check("spi_irq", spi_irq, 0);    // RX drained
      // Overfill TX with the master held off
      write_reg(`SPI_REG_CONFIG, cfg_word(1'b0, 1'b0, 8'd0));
      for (int i = 0; i <= `SPI_TX_DEPTH; i++)
         write_reg(`SPI_REG_TX, 32'($urandom));
      read_reg(`SPI_REG_STATUS, d);
      check("STATUS", d, 32'h18);      // tx_full and tx_overflow
      write_reg(`SPI_REG_STATUS, 32'd0);
      read_reg(`SPI_REG_STATUS, d);
      check("STATUS", d, 32'h10);      // Overflow cleared, still full
   endtask

   // ######################################################################
   // Main sequence

   initial begin
      logic [31:0] seed;
      arst_n     <= 1'b0;
      access_in  <= 1'b0;
      packet_in  <= '0;
      wait_in    <= 1'b0;
      cycles     = 0;
      sent_total = 0;
      prev_rx    = 8'h00;              // First reply is zero
      exp_cfg    = 32'd0;
      seed       = $urandom(32'hd16b2b56);
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;
      reset_values();
      register_access();
      loopback_run(8'd0, 4);
      loopback_run(8'd3, 4);
      backpressure();
      irq_and_overflow();
      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire
